// ==== verilog/qsnd_pkg.sv ====
`default_nettype none

package qsnd_pkg;

    // address map, page is addr[15:12]
    localparam logic [3:0] RAM_PAGE_LO = 4'hC;
    localparam logic [3:0] RAM_PAGE_HI = 4'hF;
    localparam logic [3:0] REG_PAGE = 4'hD;
    localparam logic [2:0] REG_DATA_HI = 3'd0;
    localparam logic [2:0] REG_DATA_LO = 3'd1;
    localparam logic [2:0] REG_DSP_ADDR = 3'd2;
    localparam logic [2:0] REG_BANK = 3'd3;
    localparam logic [2:0] REG_STATUS = 3'd7;
    localparam logic [18:0] BANK_BASE = 19'h08000; // banked ROM starts after the fixed 32 kB
    localparam logic [3:0] WAIT_PAGE_MIN = 4'h4;

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  dout;   // write data from the Z80
        logic        mreq_n;
        logic        rd_n;
        logic        wr_n;
        logic        m1_n;
        logic        iorq_n;
    } z80_bus_t;

    typedef struct packed {
        logic [16:1] addr;   // word address
        logic [7:0]  dout;   // low byte only
        logic        ldsw_n;
        logic        buse_n; // 68000 wants the bus
    } main_bus_t;

    typedef struct packed {
        logic        win;      // set for 0x8000 and up
        logic        bank_sel; // must be clear inside the bank window
        logic [13:0] offset;
    } z80_rom_view_t;

    typedef struct packed {
        logic [3:0] page;
        logic [8:0] unused;
        logic [2:0] idx;
    } z80_io_view_t;

    typedef union packed {
        z80_rom_view_t rom;
        z80_io_view_t  io;
    } z80_addr_u;

    typedef struct packed {
        logic [7:0]  addr;
        logic [15:0] data;
    } dsp_cmd_t;

    typedef struct packed {
        logic        irq;
        logic        reset;
        logic [15:0] pbus;   // parallel input word
    } dsp_link_t;

    typedef struct packed {
        logic       rom_cs;
        logic       ram_cs;
        logic       reg_wr;
        logic       bank_wr;
        logic       stat_rd;
        logic [2:0] idx;
    } qreg_sel_t;

endpackage

`default_nettype wire

// ==== verilog/m68_bus_lock.sv ====
`timescale 1ns/1ps
`default_nettype none

module m68_bus_lock (
    input  logic                 clk48,
    input  logic                 rst,
    input  logic                 cen8,
    input  qsnd_pkg::main_bus_t  main,
    input  logic                 busak_n,
    output logic                 busrq_n,
    output logic                 main_own
);

    logic [1:0] latch;

    assign busrq_n = main.buse_n;   // request passed straight to the Z80
    assign main_own = latch[1];

    // grant needs two cen8 ticks of request and acknowledge
    always_ff @(posedge clk48, posedge rst) begin
        if (rst) begin
            latch <= 2'b11;
        end else if (main.buse_n) begin
            latch <= 2'b11;
        end else if (cen8) begin
            latch <= {latch[0], busrq_n | busak_n};
        end
    end

endmodule

`default_nettype wire

// ==== verilog/z80_bus_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module z80_bus_decode #(
    parameter int ram_aw = 13
) (
    input  logic                 clk48,
    input  logic                 rst,
    input  qsnd_pkg::z80_bus_t   z80,
    input  qsnd_pkg::main_bus_t  main,
    input  logic                 main_own,
    input  logic                 rom_ok,
    input  logic [7:0]           rom_data,
    input  logic [7:0]           ram_q,
    input  logic [3:0]           bank,
    input  logic                 dsp_rdy_n,
    output qsnd_pkg::qreg_sel_t  sel,
    output logic [7:0]           wr_data,
    output logic [18:0]          rom_addr,
    output logic [ram_aw-1:0]    ram_addr,
    output logic                 ram_we,
    output logic [7:0]           cpu_din,
    output logic [7:0]           main_din,
    output logic                 main_busakn
);
    import qsnd_pkg::*;

    z80_addr_u a;
    logic      bus_mreq_n;
    logic      bus_wr_n;
    logic      bus_rd_n;
    logic      reg_page;
    logic      main_own_dly;
    logic      rom_ok2;

    // 68000 takes over address, data and write strobe while it owns the bus
    assign a = main_own ? z80.addr : main.addr;
    assign wr_data = main_own ? z80.dout : main.dout;
    assign bus_wr_n = main_own ? z80.wr_n : main.ldsw_n;
    assign bus_rd_n = main_own ? z80.rd_n : ~main.ldsw_n;
    assign bus_mreq_n = main_own & z80.mreq_n; // forced active for the 68000

    assign reg_page = a.io.page == REG_PAGE;

    assign ram_addr = a[ram_aw-1:0];
    assign ram_we = sel.ram_cs && !bus_wr_n;

    always_ff @(posedge clk48, posedge rst) begin
        if (rst) begin
            sel <= '0;
            rom_ok2 <= 1'b0;
            main_own_dly <= 1'b1;
        end else begin
            rom_ok2 <= rom_ok;
            main_own_dly <= main_own;
            sel.rom_cs <= !bus_mreq_n && (!a.rom.win || !a.rom.bank_sel);
            sel.ram_cs <= !bus_mreq_n &&
                          (a.io.page == RAM_PAGE_LO || a.io.page == RAM_PAGE_HI);
            sel.reg_wr <= !bus_mreq_n && !bus_wr_n && reg_page && a.io.idx <= REG_DSP_ADDR;
            sel.bank_wr <= !bus_mreq_n && !bus_wr_n && reg_page && a.io.idx == REG_BANK;
            sel.stat_rd <= !bus_mreq_n && !bus_rd_n && reg_page && a.io.idx == REG_STATUS;
            sel.idx <= a.io.idx;
        end
    end

    // ROM address follows the last active cycle
    always_ff @(posedge clk48) begin
        if (!bus_mreq_n) begin
            if (a.rom.win)
                rom_addr <= BANK_BASE + {1'b0, bank, a.rom.offset}; // 16 kB banks
            else
                rom_addr <= {3'b000, a};
        end
        main_din <= cpu_din;
    end

    always_comb begin
        if (sel.rom_cs)
            cpu_din = rom_data;   // no decryption
        else if (sel.ram_cs)
            cpu_din = ram_q;
        else if (sel.stat_rd)
            cpu_din = {dsp_rdy_n, 3'b111, bank};
        else
            cpu_din = 8'hff;
    end

    // hold the 68000 off while a ROM fetch is still pending
    assign main_busakn = main_own_dly | (sel.rom_cs & ~rom_ok2);

    a_one_cs: assert property (@(posedge clk48) disable iff (rst)
        $onehot0({sel.rom_cs, sel.ram_cs, sel.reg_wr, sel.bank_wr, sel.stat_rd}));

endmodule

`default_nettype wire

// ==== verilog/z80_work_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module z80_work_ram #(
    parameter int ram_aw = 13
) (
    input  logic              clk48,
    input  logic [ram_aw-1:0] addr,
    input  logic [7:0]        data,
    input  logic              we,
    output logic [7:0]        q
);

    logic [7:0] mem [2**ram_aw];

    // read returns the old byte during a write
    always_ff @(posedge clk48) begin
        if (we)
            mem[addr] <= data;
        q <= mem[addr];
    end

endmodule

`default_nettype wire

// ==== verilog/qsnd_cmd_latch.sv ====
`timescale 1ns/1ps
`default_nettype none

module qsnd_cmd_latch (
    input  logic                 clk48,
    input  logic                 rst,
    input  qsnd_pkg::qreg_sel_t  sel,
    input  logic [7:0]           wr_data,
    input  logic                 dsp_pids_n,
    input  logic                 dsp_iack,
    output logic [3:0]           bank,
    output logic                 dsp_rdy_n,
    output qsnd_pkg::dsp_link_t  dsp
);
    import qsnd_pkg::*;

    dsp_cmd_t   cmd;
    logic       dsp_rst;
    logic       irq;
    logic [1:0] datasel;     // 11 address step, 01 data step, 00 idle
    logic       last_pids_n;

    always_ff @(posedge clk48, posedge rst) begin
        if (rst) begin
            bank <= 4'd0;
            dsp_rst <= 1'b1;
            cmd <= '0;
        end else begin
            if (sel.bank_wr) begin
                bank <= wr_data[3:0];
                dsp_rst <= ~wr_data[7]; // bit 7 releases the DSP
            end
            if (sel.reg_wr) begin
                case (sel.idx)
                    REG_DATA_HI: cmd.data[15:8] <= wr_data;
                    REG_DATA_LO: cmd.data[7:0] <= wr_data;
                    REG_DSP_ADDR: cmd.addr <= wr_data;
                    default: ;
                endcase
            end
        end
    end

    // irq and data-select sequencing
    always_ff @(posedge clk48, posedge rst) begin
        if (rst) begin
            irq <= 1'b0;
            datasel <= 2'b00;
            last_pids_n <= 1'b1;
        end else begin
            last_pids_n <= dsp_pids_n;
            if (sel.reg_wr && sel.idx == REG_DSP_ADDR) begin
                irq <= 1'b1;
                datasel <= 2'b11;
            end else if (dsp_pids_n && !last_pids_n) begin
                irq <= 1'b0;                // DSP took the address
                datasel <= datasel >> 1;
            end
        end
    end

    assign dsp.irq = irq;
    assign dsp.reset = dsp_rst;
    assign dsp.pbus = datasel[1] ? {8'd0, cmd.addr} : cmd.data;

    assign dsp_rdy_n = ~(irq | dsp_iack);

    a_datasel: assert property (@(posedge clk48) disable iff (rst)
        datasel != 2'b10);

endmodule

`default_nettype wire

// ==== verilog/z80_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

module z80_timing #(
    parameter int int_period = 32000
) (
    input  logic                clk48,
    input  logic                rst,
    input  logic                cen8,
    input  qsnd_pkg::z80_bus_t  z80,
    output logic                int_n,
    output logic                cen_cpu
);
    import qsnd_pkg::*;

    localparam int cw = $clog2(int_period);

    logic [cw-1:0] cnt;
    logic          wrap;
    logic          wait_flag;

    assign wrap = cnt == cw'(int_period - 1);

    always_ff @(posedge clk48, posedge rst) begin
        if (rst) begin
            cnt <= '0;
            int_n <= 1'b1;
        end else if (cen8) begin
            cnt <= wrap ? '0 : cnt + 1'b1;
            if (!z80.m1_n && !z80.iorq_n)
                int_n <= 1'b1;      // interrupt acknowledge cycle
            else if (wrap)
                int_n <= 1'b0;
        end
    end

    // one extra wait state on opcode fetches from page 4 and up
    always_ff @(posedge clk48, posedge rst) begin
        if (rst) begin
            wait_flag <= 1'b0;
        end else if (cen8) begin
            if (wait_flag)
                wait_flag <= 1'b0;
            else if (!z80.m1_n && z80.addr[15:12] >= WAIT_PAGE_MIN)
                wait_flag <= 1'b1;
        end
    end

    assign cen_cpu = cen8 & ~wait_flag;

    // a swallowed tick is never followed by another
    a_no_stall: assert property (@(posedge clk48) disable iff (rst)
        cen8 && !cen_cpu |=> !wait_flag);

endmodule

`default_nettype wire

// ==== verilog/qsound_z80_glue.sv ====
`timescale 1ns/1ps
`default_nettype none

module qsound_z80_glue #(
    parameter int int_period = 32000,
    parameter int ram_aw = 13
) (
    input  logic                 clk48,
    input  logic                 rst,
    input  logic                 cen8,
    input  qsnd_pkg::z80_bus_t   z80,
    input  logic                 busak_n,
    input  logic                 rom_ok,
    input  logic                 dsp_pids_n,
    input  logic                 dsp_iack,
    input  qsnd_pkg::main_bus_t  main,
    input  logic [7:0]           rom_data,
    output logic [7:0]           z80_din,
    output logic [7:0]           main_din,
    output logic                 busrq_n,
    output logic                 main_busakn,
    output logic                 int_n,
    output logic                 cen_cpu,
    output logic                 rom_cs,
    output logic [18:0]          rom_addr,
    output qsnd_pkg::dsp_link_t  dsp
);
    import qsnd_pkg::*;

    logic              main_own;
    qreg_sel_t         sel;
    logic [7:0]        wr_data;
    logic [ram_aw-1:0] ram_addr;
    logic              ram_we;
    logic [7:0]        ram_q;
    logic [3:0]        bank;
    logic              dsp_rdy_n;

    assign rom_cs = sel.rom_cs;

    m68_bus_lock u_lock (
        .clk48(clk48), .rst(rst), .cen8(cen8), .main(main),
        .busak_n(busak_n), .busrq_n(busrq_n), .main_own(main_own)
    );

    z80_bus_decode #(.ram_aw(ram_aw)) u_dec (
        .clk48(clk48), .rst(rst), .z80(z80), .main(main), .main_own(main_own),
        .rom_ok(rom_ok), .rom_data(rom_data), .ram_q(ram_q), .bank(bank),
        .dsp_rdy_n(dsp_rdy_n), .sel(sel), .wr_data(wr_data), .rom_addr(rom_addr),
        .ram_addr(ram_addr), .ram_we(ram_we), .cpu_din(z80_din),
        .main_din(main_din), .main_busakn(main_busakn)
    );

    z80_work_ram #(.ram_aw(ram_aw)) u_ram (
        .clk48(clk48), .addr(ram_addr), .data(wr_data), .we(ram_we), .q(ram_q)
    );

    qsnd_cmd_latch u_cmd (
        .clk48(clk48), .rst(rst), .sel(sel), .wr_data(wr_data),
        .dsp_pids_n(dsp_pids_n), .dsp_iack(dsp_iack), .bank(bank),
        .dsp_rdy_n(dsp_rdy_n), .dsp(dsp)
    );

    z80_timing #(.int_period(int_period)) u_tim (
        .clk48(clk48), .rst(rst), .cen8(cen8), .z80(z80),
        .int_n(int_n), .cen_cpu(cen_cpu)
    );

endmodule

`default_nettype wire

// ==== tb/tb_tasks.svh ====
// bus cycle models and compare tasks

task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
        $display("ERROR %s: expected %h, actual %h", name, exp, act);
        errors++;
    end
endtask

task automatic check_addr19(input string name, input logic [18:0] exp, input logic [18:0] act);
    if (act !== exp) begin
        $display("ERROR %s: expected %h, actual %h", name, exp, act);
        errors++;
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("ERROR %s: expected %b, actual %b", name, exp, act);
        errors++;
    end
endtask

task automatic check_link(input string name, input dsp_link_t exp, input dsp_link_t act);
    if (act !== exp) begin
        $display("ERROR %s: expected %h, actual %h", name, exp, act);
        errors++;
    end
endtask

task automatic bus_release();
    z80.mreq_n = 1'b1;
    z80.rd_n = 1'b1;
    z80.wr_n = 1'b1;
    z80.m1_n = 1'b1;
    z80.iorq_n = 1'b1;
    @(negedge clk48);   // one idle cycle between accesses
endtask

task automatic z80_write(input logic [15:0] addr, input logic [7:0] data);
    z80.addr = addr;
    z80.dout = data;
    z80.mreq_n = 1'b0;
    z80.wr_n = 1'b0;
    repeat (2) @(posedge clk48);   // selects, then the write itself
    @(negedge clk48);
    bus_release();
endtask

task automatic z80_read(input logic [15:0] addr, output logic [7:0] data,
                        output logic [18:0] raddr, output logic cs);
    z80.addr = addr;
    z80.mreq_n = 1'b0;
    z80.rd_n = 1'b0;
    @(negedge clk48);
    data = z80_din;
    raddr = rom_addr;
    cs = rom_cs;
    bus_release();
endtask

// holds an opcode fetch for a number of cen8 ticks, counts cen_cpu pulses
task automatic z80_fetch(input logic [15:0] addr, input int ticks, output int pulses);
    int seen;
    seen = 0;
    pulses = 0;
    z80.addr = addr;
    z80.mreq_n = 1'b0;
    z80.rd_n = 1'b0;
    z80.m1_n = 1'b0;
    while (seen < ticks) begin
        @(negedge clk48);
        #1;
        if (cen8) seen++;
        if (cen_cpu) pulses++;
    end
    @(negedge clk48);
    bus_release();
endtask

// ==== tb/tb_qsound_z80_glue.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_qsound_z80_glue;
    import qsnd_pkg::*;

    localparam int INT_PERIOD = 200;
    localparam int NUM_TESTS = 6;
    localparam longint LIMIT_NS = 64'd8 * (20 * INT_PERIOD * 6 + 2000 * NUM_TESTS);

    logic clk48, rst, cen8, busak_n, rom_ok, dsp_pids_n, dsp_iack, busrq_n;
    logic main_busakn, int_n, cen_cpu, rom_cs;
    logic [7:0] rom_data, z80_din, main_din, rd, b0, b1;
    logic [18:0] rom_addr, ra, exp_ra;
    z80_bus_t z80;
    main_bus_t main;
    dsp_link_t dsp;
    int errors, test_err, seed, cen_cnt, n, off, pulses;
    logic exp_reset, rcs;
    logic [15:0] dword;
    logic [7:0] dbyte;

    qsound_z80_glue #(.int_period(INT_PERIOD), .ram_aw(13)) u_dut (
        .clk48(clk48), .rst(rst), .cen8(cen8), .z80(z80), .busak_n(busak_n),
        .rom_ok(rom_ok), .dsp_pids_n(dsp_pids_n), .dsp_iack(dsp_iack), .main(main),
        .rom_data(rom_data), .z80_din(z80_din), .main_din(main_din), .busrq_n(busrq_n),
        .main_busakn(main_busakn), .int_n(int_n), .cen_cpu(cen_cpu), .rom_cs(rom_cs),
        .rom_addr(rom_addr), .dsp(dsp)
    );

    assign rom_data = rom_addr[7:0] ^ rom_addr[15:8];  // ROM model
    assign busak_n = busrq_n;                           // Z80 grants at once

    `include "tb_tasks.svh"

    initial begin
        clk48 = 1'b0;
        forever #4 clk48 = ~clk48;
    end

    always @(negedge clk48) begin   // one cen8 in six clocks
        cen_cnt <= (cen_cnt == 5) ? 0 : cen_cnt + 1;
        cen8 <= (cen_cnt == 5);
    end

    initial begin
        #(LIMIT_NS);
        $display("watchdog: simulation ran past its time limit");
        $display("TEST FAILED");
        $finish;
    end

    task automatic report_test(input string name);
        if (errors == test_err)
            $display("%s: ok", name);
        else
            $display("%s: %0d errors", name, errors - test_err);
        test_err = errors;
    endtask

    initial begin
        errors = 0;
        test_err = 0;
        seed = 83477;
        cen_cnt = 0;
        cen8 = 1'b0;
        rst = 1'b1;
        rom_ok = 1'b1;
        dsp_pids_n = 1'b1;
        dsp_iack = 1'b0;
        z80 = '{addr: 16'h0, dout: 8'h0, default: 1'b1};
        main = '{addr: 16'hc000, dout: 8'h0, ldsw_n: 1'b1, buse_n: 1'b1};
        exp_reset = 1'b1;
        repeat (2) @(posedge clk48);
        @(negedge clk48);
        rst = 1'b0;
        @(negedge clk48);

        n = $random(seed) & 15;
        off = $random(seed) & 16'h3fff;
        exp_ra = 19'h08000 + 19'(n) * 19'h4000 + 19'(off);
        z80_write(16'hd003, 8'(n));
        z80_read(16'h8000 + 16'(off), rd, ra, rcs);
        check_addr19("rom_bank addr", exp_ra, ra);
        check_byte("rom_bank data", exp_ra[7:0] ^ exp_ra[15:8], rd);
        check_bit("rom_bank cs", 1'b1, rcs);
        z80_read(16'h1234, rd, ra, rcs);
        check_addr19("rom_low addr", 19'h01234, ra);
        check_byte("rom_low data", 8'h26, rd);
        check_bit("rom_low cs", 1'b1, rcs);
        report_test("rom_banking");

        for (int i = 0; i < 4; i++) begin
            b0 = 8'($random(seed));
            b1 = ~b0;   // different bytes expose aliasing
            z80_write(16'hc000 + 16'(i), b0);
            z80_write(16'hf000 + 16'(i), b1);
            z80_read(16'hc000 + 16'(i), rd, ra, rcs);
            check_byte("ram page c", b0, rd);
            check_bit("ram page c cs", 1'b0, rcs);
            z80_read(16'hf000 + 16'(i), rd, ra, rcs);
            check_byte("ram page f", b1, rd);
        end
        report_test("ram");

        dword = 16'($random(seed));
        dbyte = 8'($random(seed));
        z80_write(16'hd000, dword[15:8]);
        z80_write(16'hd001, dword[7:0]);
        z80_write(16'hd002, dbyte);
        check_link("dsp addr step", dsp_link_t'{1'b1, exp_reset, {8'h00, dbyte}}, dsp);
        z80_read(16'hd007, rd, ra, rcs);
        check_bit("status ready", 1'b0, rd[7]);
        dsp_pids_n = 1'b0;
        repeat (2) @(negedge clk48);
        dsp_pids_n = 1'b1;
        repeat (3) @(negedge clk48);
        check_link("dsp data step", dsp_link_t'{1'b0, exp_reset, dword}, dsp);
        report_test("dsp_command");

        check_bit("dsp reset idle", 1'b1, dsp.reset);
        z80_write(16'hd003, 8'h80 | 8'(n));
        check_bit("dsp reset released", 1'b0, dsp.reset);
        z80_write(16'hd003, 8'(n));
        check_bit("dsp reset held", 1'b1, dsp.reset);
        report_test("dsp_reset");

        for (int i = 0; i < (INT_PERIOD + 2) * 6 && int_n; i++)
            @(negedge clk48);
        if (int_n) begin
            $display("int_n never fell within the interrupt period");
            errors++;
        end
        z80.m1_n = 1'b0;
        z80.iorq_n = 1'b0;
        repeat (7) @(negedge clk48);   // spans one cen8 tick
        bus_release();
        check_bit("int_n after ack", 1'b1, int_n);
        repeat (7) @(negedge clk48);
        z80_fetch(16'h5000, 4, pulses);
        if (pulses != 2) begin
            $display("ERROR wait page 5: expected 2, actual %0d", pulses);
            errors++;
        end
        z80_fetch(16'h1000, 4, pulses);
        if (pulses != 4) begin
            $display("ERROR wait page 1: expected 4, actual %0d", pulses);
            errors++;
        end
        report_test("timing");

        b0 = 8'($random(seed));
        main.addr = 16'hc000 + 16'(n);
        main.buse_n = 1'b0;
        for (int i = 0; i < 100 && main_busakn; i++)
            @(negedge clk48);
        if (main_busakn) begin
            $display("main_busakn never fell after the bus request");
            errors++;
        end
        check_bit("busrq_n", main.buse_n, busrq_n);
        main.dout = b0;
        main.ldsw_n = 1'b0;
        repeat (3) @(negedge clk48);
        main.ldsw_n = 1'b1;
        repeat (3) @(negedge clk48);
        check_byte("main read", b0, main_din);
        main.buse_n = 1'b1;
        repeat (3) @(negedge clk48);
        z80_read(16'hc000 + 16'(n), rd, ra, rcs);
        check_byte("z80 after main write", b0, rd);
        report_test("bus_lock");

        $display("checks done: %0d errors in %0d tests", errors, NUM_TESTS);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== qsound_z80_glue.f ====
+incdir+tb
verilog/qsnd_pkg.sv
verilog/m68_bus_lock.sv
verilog/z80_bus_decode.sv
verilog/z80_work_ram.sv
verilog/qsnd_cmd_latch.sv
verilog/z80_timing.sv
verilog/qsound_z80_glue.sv
tb/tb_qsound_z80_glue.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_qsound_z80_glue
FILELIST ?= qsound_z80_glue.f
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJDIR)
